//--- tb.f
+incdir+test
logic/phasePkg.sv
logic/cpuPkg.sv
logic/decadeCounter.sv
logic/phaser.sv
logic/fetchUnit.sv
logic/decoder.sv
logic/execUnit.sv
logic/cpuTop.sv
test/cpuTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module cpuTb -o cpuTbSim

out=$(./obj_dir/cpuTbSim)
echo "$out"

if echo "$out" | grep -qx "Everything OK"; then
    exit 0
else
    exit 1
fi

//--- test/tbCases.svh
`ifndef TBCASES_SVH
`define TBCASES_SVH

// test programs and what the out port should show for each
// slot = index of the out instruction in the executed stream, counted from 0
// the byte is expected in the clock that starts 4*slot+4 clocks after reset release

localparam int caseCount = 4;

typedef struct packed {
    logic [31:0][15:0] prog;     // program words from address 0
    logic [5:0]        progLen;
    logic [4:0]        outCount;
    logic [15:0][7:0]  outBytes;
    logic [15:0][7:0]  outSlots;
    logic [7:0]        haltSlot; // executed index of the halt
} caseT;

caseT        cases [caseCount];
logic [15:0] progQ [$];  // scratch lists, copied into the table by storeCase
logic [7:0]  outQ [$];
logic [7:0]  slotQ [$];
logic [31:0] lfsrState;

// opcode, rd, rs, 8 unused bits
function automatic logic [15:0] regWord(input opcodeT op, input int rd, input int rs);
    return {op, 2'(rd), 2'(rs), 8'h00};
endfunction

// opcode, rd, 2 unused bits, immediate or target
function automatic logic [15:0] immWord(input opcodeT op, input int rd, input logic [7:0] imm);
    return {op, 2'(rd), 2'b00, imm};
endfunction

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic randomByte(output logic [7:0] b);
    b = '0;
    for (int i = 0; i < 8; i++) begin
        lfsrState = lfsrStep(lfsrState); // one step per bit
        b = {b[6:0], lfsrState[0]};
    end
endtask

task automatic storeCase(input int c, input int haltSlot);
    cases[c]          = '0;
    cases[c].progLen  = 6'(progQ.size());
    cases[c].outCount = 5'(outQ.size());
    cases[c].haltSlot = 8'(haltSlot);
    foreach (progQ[i]) begin
        cases[c].prog[i] = progQ[i];
    end
    foreach (outQ[i]) begin
        cases[c].outBytes[i] = outQ[i];
        cases[c].outSlots[i] = slotQ[i];
    end
endtask

task automatic fillCases();
    logic [7:0] imm;
    logic [7:0] sum;
    // every alu op, last addi wraps past 255
    progQ = '{immWord(opLdi, 0, 8'h5a), immWord(opLdi, 1, 8'h3c),
              regWord(opMov, 2, 0), regWord(opAdd, 2, 1), regWord(opOut, 2, 0),
              regWord(opSub, 1, 0), regWord(opOut, 1, 0),
              regWord(opMov, 3, 0), regWord(opAnd, 3, 1), regWord(opOut, 3, 0),
              regWord(opOr, 3, 1), regWord(opXor, 3, 0), regWord(opOut, 3, 0),
              immWord(opAddi, 0, 8'hc0), regWord(opOut, 0, 0), regWord(opHalt, 0, 0)};
    outQ  = '{8'h96, 8'he2, 8'h42, 8'hb8, 8'h1a};
    slotQ = '{8'd4, 8'd6, 8'd9, 8'd12, 8'd14};
    storeCase(0, 15);
    // jmp over addresses 2 and 3, then count r0 down from 3 with jnz
    progQ = '{immWord(opLdi, 0, 8'h03), immWord(opJmp, 0, 8'h04),
              immWord(opLdi, 0, 8'hee), regWord(opHalt, 0, 0),
              regWord(opOut, 0, 0), immWord(opAddi, 0, 8'hff), immWord(opJnz, 0, 8'h04),
              immWord(opLdi, 2, 8'h77), regWord(opOut, 2, 0), regWord(opHalt, 0, 0)};
    outQ  = '{8'h03, 8'h02, 8'h01, 8'h77};
    slotQ = '{8'd2, 8'd5, 8'd8, 8'd12};
    storeCase(1, 13);
    // random immediates, running sum mod 256 shown after every step
    progQ.delete();
    outQ.delete();
    slotQ.delete();
    lfsrState = 32'h23db0f67;
    sum       = '0;
    for (int k = 0; k < 6; k++) begin
        randomByte(imm);
        sum = sum + imm;
        if (k == 0) begin
            progQ.push_back(immWord(opLdi, 1, imm));
        end else begin
            progQ.push_back(immWord(opAddi, 1, imm));
        end
        progQ.push_back(regWord(opOut, 1, 0));
        outQ.push_back(sum);
        slotQ.push_back(8'(2 * k + 1));
    end
    progQ.push_back(regWord(opHalt, 0, 0));
    storeCase(2, 12);
    // 0x80 doubled wraps to zero, the out after halt must never show
    progQ = '{immWord(opLdi, 3, 8'h80), regWord(opOut, 3, 0), regWord(opAdd, 3, 3),
              regWord(opOut, 3, 0), regWord(opHalt, 0, 0), regWord(opOut, 3, 0)};
    outQ  = '{8'h80, 8'h00};
    slotQ = '{8'd1, 8'd3};
    storeCase(3, 4);
endtask

`endif

//--- test/cpuTb.sv
`timescale 1ns/1ps

// testbench that runs each table program on cpuTop from reset to halt
// checks phases, fetch range, out port data and timing, halt behavior
module cpuTb
    import phasePkg::*, cpuPkg::*;
();

    `include "tbCases.svh"

    localparam int cycleLimit = caseCount * (32 * 4 + 8);

    logic                 clk;
    logic                 arstN;
    instrT                imemData;
    logic [addrWidth-1:0] imemAddr;
    phaseT                phase;
    logic                 outValid;
    logic [dataWidth-1:0] outData;
    logic                 halted;

    logic [15:0] rom [256];  // program memory model
    caseT        cur;        // case being run
    int          caseIdx;
    int          cyc;        // clocks since reset release
    int          totalCycles;
    int          outIdx;     // outputs seen in this case
    bit          sawHalt;
    bit          running;    // monitor active
    int          mismatches;
    int          failures;
    phaseT       expPhase;

    cpuTop DUT (
        .clk      (clk),
        .arstN    (arstN),
        .imemData (imemData),
        .imemAddr (imemAddr),
        .phase    (phase),
        .outValid (outValid),
        .outData  (outData),
        .halted   (halted)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // pc only moves on edges, so a read 2 ns later is as good as combinational
    always @(posedge clk) begin
        #2;
        imemData = rom[imemAddr];
    end

    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    always @(posedge clk) begin
        totalCycles = totalCycles + 1;
        if (totalCycles >= cycleLimit) begin
            $display("timeout: run still going after %0d cycles", totalCycles);
            $display("Something failed");
            $finish;
        end
    end

    // halt opcode in the top nibble, address in the low byte
    task automatic loadRom();
        for (int a = 0; a < 256; a++) begin
            rom[a] = {4'hf, 4'h0, 8'(a)};
        end
        for (int a = 0; a < int'(cur.progLen); a++) begin
            rom[a] = cur.prog[a];
        end
    endtask

    // sampled mid-cycle, away from the edges
    always @(negedge clk) begin
        if (arstN && running) begin
            expPhase = '0; // dead step, or parked after halt
            if (!halted) begin
                expPhase.fetch  = (cyc % 4 == 1);
                expPhase.decode = (cyc % 4 == 2);
                expPhase.exec   = (cyc % 4 == 3);
            end
            if (phase !== expPhase) begin
                mismatches++;
                $display("MISMATCH phase: case %0d cycle %0d got %h expected %h",
                         caseIdx, cyc, phase, expPhase);
            end
            if (phase.fetch && int'(imemAddr) >= int'(cur.progLen)) begin
                failures++;
                $display("case %0d: fetch from address %0d beyond the program at cycle %0d",
                         caseIdx, imemAddr, cyc);
            end
            if (halted && !sawHalt) begin
                sawHalt = 1'b1;
                if (cyc != 4 * int'(cur.haltSlot) + 4) begin
                    mismatches++;
                    $display("MISMATCH halted cycle: case %0d got %h expected %h",
                             caseIdx, cyc, 4 * int'(cur.haltSlot) + 4);
                end
            end
            if (sawHalt && !halted) begin
                failures++;
                $display("case %0d: halted dropped at cycle %0d", caseIdx, cyc);
            end
            if (outValid) begin
                if (halted) begin
                    failures++;
                    $display("case %0d: output strobe while halted", caseIdx);
                end else if (outIdx >= int'(cur.outCount)) begin
                    failures++;
                    $display("case %0d: unexpected extra output at cycle %0d", caseIdx, cyc);
                end else begin
                    if (outData !== cur.outBytes[outIdx]) begin
                        mismatches++;
                        $display("MISMATCH outData: case %0d output %0d got %h expected %h",
                                 caseIdx, outIdx, outData, cur.outBytes[outIdx]);
                    end
                    if (cyc != 4 * int'(cur.outSlots[outIdx]) + 4) begin
                        mismatches++;
                        $display("MISMATCH outValid cycle: case %0d output %0d got %h expected %h",
                                 caseIdx, outIdx, cyc, 4 * int'(cur.outSlots[outIdx]) + 4);
                    end
                end
                outIdx++;
            end
        end
    end

    initial begin
        arstN    = 1'b0;
        imemData = '0;
        running  = 1'b0;
        fillCases();
        for (int c = 0; c < caseCount; c++) begin
            @(posedge clk);
            #2;
            arstN   = 1'b0;
            caseIdx = c;
            cur     = cases[c];
            loadRom();
            outIdx  = 0;
            sawHalt = 1'b0;
            repeat (4) @(posedge clk);
            #2;
            arstN   = 1'b1;
            running = 1'b1;
            while (!halted) begin
                @(negedge clk);
            end
            repeat (8) @(negedge clk); // halted must stay quiet
            @(posedge clk);
            #2;
            running = 1'b0;
            if (outIdx != int'(cur.outCount)) begin
                failures++;
                $display("case %0d: saw %0d outputs but expected %0d",
                         c, outIdx, cur.outCount);
            end
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule : cpuTb

//--- logic/cpuTop.sv
`timescale 1ns/1ps

// core top: step counter, phaser and the three units
module cpuTop
    import phasePkg::*, cpuPkg::*;
(
    input  logic                 clk,
    input  logic                 arstN,
    input  instrT                imemData,
    output logic [addrWidth-1:0] imemAddr,
    output phaseT                phase,
    output logic                 outValid,
    output logic [dataWidth-1:0] outData,
    output logic                 halted
);

    logic [seqWidth-1:0]  seq;
    logic                 truncate;
    instrT                instr;
    ctrlT                 ctrl;
    logic                 branchTaken;
    logic [addrWidth-1:0] branchTarget;

    // hold comes back from execUnit, so the counter lives here
    decadeCounter decade (
        .clk      (clk),
        .arstN    (arstN),
        .truncate (truncate),
        .hold     (halted),
        .seq      (seq)
    );

    phaser phases (
        .seq      (seq),
        .truncate (truncate),
        .phase    (phase)
    );

    fetchUnit fetch (
        .clk          (clk),
        .arstN        (arstN),
        .phase        (phase),
        .imemData     (imemData),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .imemAddr     (imemAddr),
        .instr        (instr)
    );

    decoder decode (
        .clk   (clk),
        .arstN (arstN),
        .phase (phase),
        .instr (instr),
        .ctrl  (ctrl)
    );

    execUnit exec (
        .clk          (clk),
        .arstN        (arstN),
        .phase        (phase),
        .ctrl         (ctrl),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .outValid     (outValid),
        .outData      (outData),
        .halted       (halted)
    );

endmodule : cpuTop

//--- logic/execUnit.sv
`timescale 1ns/1ps

// register file, ALU, zero flag, output port and halt latch
// everything commits on the edge that ends the execute step
module execUnit
    import phasePkg::*, cpuPkg::*;
(
    input  logic                 clk,
    input  logic                 arstN,
    input  phaseT                phase,
    input  ctrlT                 ctrl,
    output logic                 branchTaken,
    output logic [addrWidth-1:0] branchTarget,
    output logic                 outValid,
    output logic [dataWidth-1:0] outData,
    output logic                 halted
);

    logic [dataWidth-1:0] regs [regCount];
    logic                 zero;   // set by the last register write
    logic [dataWidth-1:0] opA;    // always rd
    logic [dataWidth-1:0] opB;    // rs or immediate
    logic [dataWidth-1:0] aluRes;

    assign opA = regs[ctrl.rd];
    assign opB = ctrl.useImm ? ctrl.immediate : regs[ctrl.rs];

    // 8-bit results with carries simply dropped
    always_comb begin
        case (ctrl.aluOp)
            aluAdd:  aluRes = opA + opB;
            aluSub:  aluRes = opA - opB;
            aluAnd:  aluRes = opA & opB;
            aluOr:   aluRes = opA | opB;
            aluXor:  aluRes = opA ^ opB;
            default: aluRes = opB; // pass, used by ldi and mov
        endcase
    end

    // fetchUnit only looks at these during execute
    assign branchTaken  = ctrl.jump | (ctrl.jumpIfNotZero & ~zero);
    assign branchTarget = addrWidth'(ctrl.immediate);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
            zero <= 1'b0;
        end else if (phase.exec && ctrl.regWrite) begin
            regs[ctrl.rd] <= aluRes;
            zero          <= (aluRes == '0);
        end
    end

    // one-clock strobe per out instruction
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
            halted   <= 1'b0;
        end else begin
            outValid <= phase.exec & ctrl.outWrite;
            if (phase.exec && ctrl.halt) begin
                halted <= 1'b1; // sticky until reset, freezes the counter
            end
        end
    end

    always_ff @(posedge clk) begin
        if (phase.exec && ctrl.outWrite) begin
            outData <= opA;
        end
    end

    // once halted the counter must stay parked
    // no writes, no execute step, no stray output strobe
    haltIsFinal: assert property (
        @(posedge clk) disable iff (!arstN)
        halted |-> !phase.exec && !outValid
    ) else $error("activity after halt");

endmodule : execUnit

//--- logic/decoder.sv
`timescale 1ns/1ps

// instruction word -> control word, registered at the end of decode
module decoder
    import phasePkg::*, cpuPkg::*;
(
    input  logic  clk,
    input  logic  arstN,
    input  phaseT phase,
    input  instrT instr,
    output ctrlT  ctrl
);

    ctrlT dec; // combinational decode of the current instr

    always_comb begin
        dec           = '0;
        dec.aluOp     = aluPass;
        dec.rd        = instr.iForm.rd;  // same bits in both views
        dec.rs        = instr.rForm.rs;  // only meaningful in register form
        dec.immediate = instr.iForm.imm; // only meaningful in immediate form
        case (instr.rForm.opcode)
            opLdi: begin
                dec.useImm   = 1'b1;
                dec.regWrite = 1'b1; // pass imm
            end
            opAddi: begin
                dec.aluOp    = aluAdd;
                dec.useImm   = 1'b1;
                dec.regWrite = 1'b1;
            end
            opAdd: begin
                dec.aluOp    = aluAdd;
                dec.regWrite = 1'b1;
            end
            opSub: begin
                dec.aluOp    = aluSub;
                dec.regWrite = 1'b1;
            end
            opAnd: begin
                dec.aluOp    = aluAnd;
                dec.regWrite = 1'b1;
            end
            opOr: begin
                dec.aluOp    = aluOr;
                dec.regWrite = 1'b1;
            end
            opXor: begin
                dec.aluOp    = aluXor;
                dec.regWrite = 1'b1;
            end
            opMov:   dec.regWrite      = 1'b1; // pass rs
            opOut:   dec.outWrite      = 1'b1;
            opJmp:   dec.jump          = 1'b1; // target in imm field
            opJnz:   dec.jumpIfNotZero = 1'b1;
            opHalt:  dec.halt          = 1'b1;
            default: ; // nop and unused codes, all enables stay low
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ctrl <= '0; // acts as nop until the first decode
        end else if (phase.decode) begin
            ctrl <= dec;
        end
    end

endmodule : decoder

//--- logic/fetchUnit.sv
`timescale 1ns/1ps

// program counter and instruction register
// memory read port is combinational, so the word is ready inside the fetch step
module fetchUnit
    import phasePkg::*, cpuPkg::*;
(
    input  logic                 clk,
    input  logic                 arstN,
    input  phaseT                phase,
    input  instrT                imemData,
    input  logic                 branchTaken,  // valid during execute
    input  logic [addrWidth-1:0] branchTarget,
    output logic [addrWidth-1:0] imemAddr,
    output instrT                instr
);

    logic [addrWidth-1:0] pc;

    assign imemAddr = pc; // address always follows pc

    // step on fetch, overwrite on a taken branch at the end of execute
    // the two phases never overlap, so order only matters for readability
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (phase.fetch) begin
            pc <= pc + addrWidth'(1); // wraps at 256
        end else if (phase.exec && branchTaken) begin
            pc <= branchTarget;
        end
    end

    // instruction register, loaded once per cycle
    always_ff @(posedge clk) begin
        if (phase.fetch) begin
            instr <= imemData;
        end
    end

endmodule : fetchUnit

//--- logic/phaser.sv
`timescale 1ns/1ps

// turns counter steps into fetch / decode / execute levels
// plain decode of seq without set/reset flops
module phaser
    import phasePkg::*;
(
    input  logic [seqWidth-1:0] seq,
    output logic                truncate,
    output phaseT               phase
);

    // step 0 has no phase and gives the first fetch a full clock after reset
    always_comb begin
        phase        = '0;
        phase.fetch  = seq[fetchStep];
        phase.decode = seq[decodeStep];
        phase.exec   = seq[execStep];
    end

    // next step after execute is the dead step again
    assign truncate = seq[execStep];

    // never two phases at once
    // two seq bits set together would show up here
    phaseExclusive: assert property (
        @(seq) $onehot0(phase)
    ) else $error("overlapping phases: %b", phase);

endmodule : phaser

//--- logic/decadeCounter.sv
`timescale 1ns/1ps

// one-hot step counter in the style of a 4017 decade counter
// truncate pulls it back to step 0, hold freezes it
module decadeCounter
    import phasePkg::*;
(
    input  logic                clk,
    input  logic                arstN,
    input  logic                truncate, // from phaser on the execute step
    input  logic                hold,     // halted core
    output logic [seqWidth-1:0] seq
);

    localparam logic [seqWidth-1:0] stepZero = seqWidth'(1);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            seq <= stepZero; // reset lands on the dead step
        end else if (hold) begin
            seq <= seq; // parked, normally at step 0
        end else if (truncate) begin
            seq <= stepZero; // cut short instead of running to 9
        end else begin
            seq <= {seq[seqWidth-2:0], seq[seqWidth-1]}; // rotate one step
        end
    end

    // exactly one step active at every edge and never past execute
    // a late truncate would let the ring run into steps 4 to 9
    seqOneHot: assert property (
        @(posedge clk) disable iff (!arstN)
        $onehot(seq) && (seq[seqWidth-1:execStep+1] == '0)
    ) else $error("seq not one-hot or past the execute step: %b", seq);

endmodule : decadeCounter

//--- logic/cpuPkg.sv
// datapath and instruction definitions for the 8-bit core
package cpuPkg;

    localparam int addrWidth = 8;  // program memory address
    localparam int dataWidth = 8;  // register and ALU width
    localparam int regCount  = 4;
    localparam int regSel    = $clog2(regCount); // register index bits

    // 4-bit opcodes, top nibble of every instruction
    typedef enum logic [3:0] {
        opNop  = 4'h0,
        opLdi  = 4'h1, // rd = imm
        opAddi = 4'h2, // rd = rd + imm
        opAdd  = 4'h3, // rd = rd + rs
        opSub  = 4'h4, // rd = rd - rs
        opAnd  = 4'h5,
        opOr   = 4'h6,
        opXor  = 4'h7,
        opMov  = 4'h8, // rd = rs
        opOut  = 4'h9, // out port = rd
        opJmp  = 4'ha, // pc = imm
        opJnz  = 4'hb, // pc = imm if zero flag clear
        opHalt = 4'hf
    } opcodeT;

    // one 16-bit word, two views
    // opcode and rd sit in the same place in both
    typedef union packed {
        struct packed {
            opcodeT              opcode;
            logic [regSel-1:0]   rd;
            logic [regSel-1:0]   rs;
            logic [7:0]          unused;
        } rForm; // register form
        struct packed {
            opcodeT              opcode;
            logic [regSel-1:0]   rd;
            logic [1:0]          unused;
            logic [dataWidth-1:0] imm; // immediate or jump target
        } iForm; // immediate form
    } instrT;

    typedef enum logic [2:0] {
        aluPass,  // second operand straight through
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor
    } aluOpT;

    // decoded control word, held from decode into execute
    typedef struct packed {
        aluOpT                aluOp;
        logic                 useImm;    // operand b from immediate, else rs
        logic [dataWidth-1:0] immediate; // also the branch target
        logic [regSel-1:0]    rd;
        logic [regSel-1:0]    rs;
        logic                 regWrite;
        logic                 outWrite;
        logic                 jump;
        logic                 jumpIfNotZero;
        logic                 halt;
    } ctrlT;

endpackage : cpuPkg

//--- logic/phasePkg.sv
// sequencing definitions shared by the step counter, phaser and the units
// one instruction = dead step, fetch, decode, execute
package phasePkg;

    // decade counter, ten one-hot outputs like the 4017 part
    localparam int seqWidth = 10;

    // step numbers of each phase
    // step 0 is dead so the fetch edge is not lost right after reset
    localparam int fetchStep  = 1;
    localparam int decodeStep = 2;
    localparam int execStep   = 3; // counter truncated after this one

    // phase levels, each high for exactly one step
    typedef struct packed {
        logic fetch;  // instruction register loads, pc steps
        logic decode; // control word registered
        logic exec;   // regs, flag, out port, branch
    } phaseT;

endpackage : phasePkg
